/* cache_mem_pkg.sv */
// fixed geometry of 32-bit words, 16-byte lines and 16 sets; only the way count is a module parameter
package cache_mem_pkg;

  ////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////

  parameter int XLEN       = 32;                 // core word width
  parameter int LINE_WORDS = 4;                  // words per line
  parameter int LINE_BITS  = XLEN * LINE_WORDS;  // 128
  parameter int SETS       = 16;                 // sets per way
  parameter int IDX_BITS   = $clog2(SETS);       // 4
  parameter int OFFS_BITS  = $clog2(LINE_WORDS); // word offset in line

  // address less index less 16-byte line offset
  parameter int TAG_BITS   = XLEN - IDX_BITS - $clog2(LINE_BITS / 8);

  parameter int DEF_WAYS   = 2;                  // default associativity

  ////////////////////////////////////////
  // vector types
  ////////////////////////////////////////

  // core data
  typedef logic [XLEN-1:0]           word_t;
  typedef logic [XLEN/8-1:0]         word_be_t;   // one bit per byte of a word

  // whole line, as stored per way
  typedef logic [LINE_BITS-1:0]      line_t;
  typedef logic [LINE_BITS/8-1:0]    line_be_t;   // byte enables over a line

  // address fields
  typedef logic [TAG_BITS-1:0]       tag_t;
  typedef logic [IDX_BITS-1:0]       idx_t;       // set index
  typedef logic [OFFS_BITS-1:0]      offs_t;      // word within line

endpackage

/* cache_req_decode.sv */
// combinational; priority flush > fill > lookup > store, store fields must hold until wb_ack_o
`timescale 1ns/100ps

module cache_req_decode #(
  parameter int WAYS = cache_mem_pkg::DEF_WAYS
) (
  input  logic                    rreq_i,        // lookup request
  input  cache_mem_pkg::idx_t     rd_idx_i,
  input  logic                    fill_i,        // line fill from bus
  input  cache_mem_pkg::idx_t     fill_idx_i,
  input  logic [WAYS-1:0]         fill_way_i,    // one-hot
  input  cache_mem_pkg::line_t    fill_line_i,
  input  logic                    fill_dirty_i,
  input  logic                    wb_req_i,      // write buffer store
  input  cache_mem_pkg::idx_t     wb_idx_i,
  input  cache_mem_pkg::offs_t    wb_offs_i,
  input  cache_mem_pkg::word_be_t wb_be_i,
  input  cache_mem_pkg::word_t    wb_data_i,
  input  logic [WAYS-1:0]         wb_ways_hit_i,
  input  logic                    flush_i,

  output cache_mem_pkg::idx_t     arr_idx_o,     // shared array index
  output logic [WAYS-1:0]         tag_we_o,
  output logic [WAYS-1:0]         dirty_we_o,
  output logic                    dirty_val_o,
  output logic [WAYS-1:0]         line_we_o,
  output cache_mem_pkg::line_be_t line_be_o,
  output cache_mem_pkg::line_t    line_data_o,
  output logic                    lookup_o,      // lookup performed this cycle
  output logic                    wb_ack_o
);

  localparam int WORD_BYTES = cache_mem_pkg::XLEN / 8;

  logic                    store_go;   // store wins the arrays
  logic [WAYS-1:0]         store_we;
  cache_mem_pkg::line_be_t store_be;

  ////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////

  // lookup loses to fill and flush
  assign lookup_o = rreq_i & ~fill_i & ~flush_i;

  // store only gets an idle cycle
  assign store_go = wb_req_i & ~flush_i & ~fill_i & ~rreq_i;
  assign wb_ack_o = store_go;

  // flush needs no index, fill first
  always_comb
  begin
    if (fill_i)
      arr_idx_o = fill_idx_i;
    else if (rreq_i)
      arr_idx_o = rd_idx_i;
    else
      arr_idx_o = wb_idx_i;
  end

  ////////////////////////////////////////
  // write enables and data
  ////////////////////////////////////////

  assign store_we   = {WAYS{store_go}} & wb_ways_hit_i;   // every hit way
  assign tag_we_o   = {WAYS{fill_i}} & fill_way_i;
  assign dirty_we_o = tag_we_o | store_we;
  assign line_we_o  = tag_we_o | store_we;

  assign dirty_val_o = fill_i ? fill_dirty_i : 1'b1;  // a store always dirties

  // place word enables at the addressed offset
  always_comb
  begin
    store_be = '0;
    for (int w = 0; w < cache_mem_pkg::LINE_WORDS; w++)
    begin
      if (wb_offs_i == cache_mem_pkg::offs_t'(w))
        store_be[w*WORD_BYTES +: WORD_BYTES] = wb_be_i;
    end
  end

  assign line_be_o   = fill_i ? {$bits(cache_mem_pkg::line_be_t){1'b1}} : store_be;
  assign line_data_o = fill_i ? fill_line_i
                              : {cache_mem_pkg::LINE_WORDS{wb_data_i}};  // word replicated

endmodule

/* cache_tag_store.sv */
// tags in inferred sync RAM, valid/dirty in flops; a fill sets valid but a flush in the same cycle wins
`timescale 1ns/100ps

module cache_tag_store #(
  parameter int WAYS = cache_mem_pkg::DEF_WAYS
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  cache_mem_pkg::idx_t             arr_idx_i,
  input  cache_mem_pkg::tag_t             fill_tag_i,
  input  logic [WAYS-1:0]                 tag_we_i,
  input  logic [WAYS-1:0]                 dirty_we_i,
  input  logic                            dirty_val_i,
  input  logic                            flush_i,     // clears every valid bit
  input  cache_mem_pkg::tag_t             rd_tag_i,    // lookup tag

  output cache_mem_pkg::tag_t [WAYS-1:0]  way_tag_o,   // stored tag per way
  output logic [WAYS-1:0]                 way_hit_o,
  output logic [WAYS-1:0]                 way_dirty_o, // valid and dirty, read set
  output logic                            any_dirty_o
);

  localparam int SETS = cache_mem_pkg::SETS;

  logic [WAYS-1:0][SETS-1:0] valid_q;
  logic [WAYS-1:0][SETS-1:0] dirty_q;
  cache_mem_pkg::idx_t       idx_q;      // index aligned with RAM output
  cache_mem_pkg::tag_t       rd_tag_q;   // lookup tag aligned with RAM output

  // same delay as the RAM read
  always_ff @(posedge clk_i)
  begin
    idx_q    <= arr_idx_i;
    rd_tag_q <= rd_tag_i;
  end

  ////////////////////////////////////////
  // tag RAM per way
  ////////////////////////////////////////

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    cache_mem_pkg::tag_t tag_mem [SETS];
    cache_mem_pkg::tag_t tag_rd_q;

    // read before write on same index
    always_ff @(posedge clk_i)
    begin
      if (tag_we_i[w])
        tag_mem[arr_idx_i] <= fill_tag_i;
      tag_rd_q <= tag_mem[arr_idx_i];
    end

    assign way_tag_o[w] = tag_rd_q;
  end

  ////////////////////////////////////////
  // valid and dirty flops
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
      dirty_q <= '0;
    end
    else
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        if (flush_i)
          valid_q[w] <= '0;                    // dirty bits stay, masked by valid
        else if (tag_we_i[w])
          valid_q[w][arr_idx_i] <= 1'b1;

        if (dirty_we_i[w])
          dirty_q[w][arr_idx_i] <= dirty_val_i;  // fill value or store
      end
    end
  end

  // compare on the delayed set
  always_comb
  begin
    for (int w = 0; w < WAYS; w++)
    begin
      way_hit_o[w]   = valid_q[w][idx_q] && (way_tag_o[w] == rd_tag_q);
      way_dirty_o[w] = valid_q[w][idx_q] && dirty_q[w][idx_q];
    end
  end

  // any valid dirty line in the whole cache
  assign any_dirty_o = |(valid_q & dirty_q);

endmodule

/* cache_data_store.sv */
// inferred sync line RAM per way, byte-enable write, old data read when index is written in same cycle
`timescale 1ns/100ps

module cache_data_store #(
  parameter int WAYS = cache_mem_pkg::DEF_WAYS
) (
  input  logic                             clk_i,
  input  cache_mem_pkg::idx_t              arr_idx_i,
  input  logic [WAYS-1:0]                  line_we_i,    // per way
  input  cache_mem_pkg::line_be_t          line_be_i,    // shared by all ways
  input  cache_mem_pkg::line_t             line_data_i,

  output cache_mem_pkg::line_t [WAYS-1:0]  way_line_o    // one cycle after index
);

  localparam int SETS       = cache_mem_pkg::SETS;
  localparam int LINE_BYTES = cache_mem_pkg::LINE_BITS / 8;

  ////////////////////////////////////////
  // line RAM per way
  ////////////////////////////////////////

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    cache_mem_pkg::line_t line_mem [SETS];
    cache_mem_pkg::line_t line_rd_q;

    always_ff @(posedge clk_i)
    begin
      // only enabled bytes change
      for (int b = 0; b < LINE_BYTES; b++)
      begin
        if (line_we_i[w] && line_be_i[b])
          line_mem[arr_idx_i][b*8 +: 8] <= line_data_i[b*8 +: 8];
      end
      line_rd_q <= line_mem[arr_idx_i];   // registered read
    end

    assign way_line_o[w] = line_rd_q;
  end

endmodule

/* cache_lookup_result.sv */
// victim_way_i must be one-hot, otherwise victim fields OR together; outputs hold between lookups
`timescale 1ns/100ps

module cache_lookup_result #(
  parameter int WAYS = cache_mem_pkg::DEF_WAYS
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             lookup_i,      // performed lookup
  input  cache_mem_pkg::idx_t              rd_idx_i,
  input  logic [WAYS-1:0]                  victim_way_i,
  input  logic [WAYS-1:0]                  way_hit_i,
  input  logic [WAYS-1:0]                  way_dirty_i,
  input  logic                             any_dirty_i,
  input  cache_mem_pkg::tag_t [WAYS-1:0]   way_tag_i,
  input  cache_mem_pkg::line_t [WAYS-1:0]  way_line_i,

  output logic                             result_valid_o,
  output logic                             hit_o,
  output logic [WAYS-1:0]                  ways_hit_o,
  output cache_mem_pkg::line_t             cache_line_o,  // zero on miss
  output cache_mem_pkg::idx_t              evict_idx_o,
  output cache_mem_pkg::tag_t              evict_tag_o,
  output cache_mem_pkg::line_t             evict_line_o,
  output logic                             way_dirty_o,   // victim way dirty
  output logic                             cache_dirty_o
);

  localparam int LINE_BITS = cache_mem_pkg::LINE_BITS;
  localparam int TAG_BITS  = cache_mem_pkg::TAG_BITS;

  logic                 lookup_q;
  cache_mem_pkg::idx_t  idx_q;
  logic [WAYS-1:0]      victim_q;
  cache_mem_pkg::line_t hit_line;
  cache_mem_pkg::line_t victim_line;
  cache_mem_pkg::tag_t  victim_tag;
  logic                 victim_dirty;

  ////////////////////////////////////////
  // align with array read
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      lookup_q <= 1'b0;
    else
      lookup_q <= lookup_i;
  end

  always_ff @(posedge clk_i)
  begin
    idx_q    <= rd_idx_i;
    victim_q <= victim_way_i;
  end

  // AND-OR muxes over the ways
  always_comb
  begin
    hit_line    = '0;
    victim_line = '0;
    victim_tag  = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      hit_line    = hit_line    | (way_line_i[w] & {LINE_BITS{way_hit_i[w]}});
      victim_line = victim_line | (way_line_i[w] & {LINE_BITS{victim_q[w]}});
      victim_tag  = victim_tag  | (way_tag_i[w]  & {TAG_BITS{victim_q[w]}});
    end
  end

  assign victim_dirty = |(way_dirty_i & victim_q);

  ////////////////////////////////////////
  // result registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      result_valid_o <= 1'b0;
      hit_o          <= 1'b0;
      ways_hit_o     <= '0;
      way_dirty_o    <= 1'b0;
      cache_dirty_o  <= 1'b0;
    end
    else
    begin
      result_valid_o <= lookup_q;     // one-cycle strobe
      if (lookup_q)
      begin
        hit_o         <= |way_hit_i;
        ways_hit_o    <= way_hit_i;
        way_dirty_o   <= victim_dirty;
        cache_dirty_o <= any_dirty_i;
      end
    end
  end

  // payload, loaded with the flags
  always_ff @(posedge clk_i)
  begin
    if (lookup_q)
    begin
      cache_line_o <= hit_line;
      evict_idx_o  <= idx_q;
      evict_tag_o  <= victim_tag;
      evict_line_o <= victim_line;
    end
  end

endmodule

/* cache_memory_top.sv */
// lookup result 2 cycles after request; fill/store/flush take effect at the sampling edge, no lookup stall
`timescale 1ns/100ps

module cache_memory_top #(
  parameter int WAYS = cache_mem_pkg::DEF_WAYS
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // lookup
  input  logic                    rreq_i,
  input  cache_mem_pkg::idx_t     rd_idx_i,
  input  cache_mem_pkg::tag_t     rd_tag_i,
  input  logic [WAYS-1:0]         victim_way_i,   // one-hot, from replacement logic

  // fill from bus
  input  logic                    fill_i,
  input  cache_mem_pkg::idx_t     fill_idx_i,
  input  cache_mem_pkg::tag_t     fill_tag_i,
  input  logic [WAYS-1:0]         fill_way_i,
  input  cache_mem_pkg::line_t    fill_line_i,
  input  logic                    fill_dirty_i,

  // write buffer store
  input  logic                    wb_req_i,
  input  cache_mem_pkg::idx_t     wb_idx_i,
  input  cache_mem_pkg::offs_t    wb_offs_i,
  input  cache_mem_pkg::word_be_t wb_be_i,
  input  cache_mem_pkg::word_t    wb_data_i,
  input  logic [WAYS-1:0]         wb_ways_hit_i,

  input  logic                    flush_i,

  output logic                    result_valid_o,
  output logic                    hit_o,
  output logic [WAYS-1:0]         ways_hit_o,
  output cache_mem_pkg::line_t    cache_line_o,
  output cache_mem_pkg::idx_t     evict_idx_o,
  output cache_mem_pkg::tag_t     evict_tag_o,
  output cache_mem_pkg::line_t    evict_line_o,
  output logic                    way_dirty_o,
  output logic                    cache_dirty_o,
  output logic                    wb_ack_o
);

  cache_mem_pkg::idx_t             arr_idx;
  logic [WAYS-1:0]                 tag_we;
  logic [WAYS-1:0]                 dirty_we;
  logic                            dirty_val;
  logic [WAYS-1:0]                 line_we;
  cache_mem_pkg::line_be_t         line_be;
  cache_mem_pkg::line_t            line_data;
  logic                            lookup;
  cache_mem_pkg::tag_t [WAYS-1:0]  way_tag;
  logic [WAYS-1:0]                 way_hit;
  logic [WAYS-1:0]                 way_dirty;
  logic                            any_dirty;
  cache_mem_pkg::line_t [WAYS-1:0] way_line;

  cache_req_decode #(.WAYS(WAYS)) cache_req_decode_i (
    .rreq_i, .rd_idx_i, .fill_i, .fill_idx_i, .fill_way_i, .fill_line_i, .fill_dirty_i,
    .wb_req_i, .wb_idx_i, .wb_offs_i, .wb_be_i, .wb_data_i, .wb_ways_hit_i, .flush_i,
    .arr_idx_o   (arr_idx),
    .tag_we_o    (tag_we),
    .dirty_we_o  (dirty_we),
    .dirty_val_o (dirty_val),
    .line_we_o   (line_we),
    .line_be_o   (line_be),
    .line_data_o (line_data),
    .lookup_o    (lookup),
    .wb_ack_o
  );

  cache_tag_store #(.WAYS(WAYS)) cache_tag_store_i (
    .clk_i, .rst_ni,
    .arr_idx_i   (arr_idx),
    .fill_tag_i,
    .tag_we_i    (tag_we),
    .dirty_we_i  (dirty_we),
    .dirty_val_i (dirty_val),
    .flush_i,
    .rd_tag_i,
    .way_tag_o   (way_tag),
    .way_hit_o   (way_hit),
    .way_dirty_o (way_dirty),
    .any_dirty_o (any_dirty)
  );

  cache_data_store #(.WAYS(WAYS)) cache_data_store_i (
    .clk_i,
    .arr_idx_i   (arr_idx),
    .line_we_i   (line_we),
    .line_be_i   (line_be),
    .line_data_i (line_data),
    .way_line_o  (way_line)
  );

  cache_lookup_result #(.WAYS(WAYS)) cache_lookup_result_i (
    .clk_i, .rst_ni,
    .lookup_i    (lookup),
    .rd_idx_i, .victim_way_i,
    .way_hit_i   (way_hit),
    .way_dirty_i (way_dirty),
    .any_dirty_i (any_dirty),
    .way_tag_i   (way_tag),
    .way_line_i  (way_line),
    .result_valid_o, .hit_o, .ways_hit_o, .cache_line_o, .evict_idx_o,
    .evict_tag_o, .evict_line_o, .way_dirty_o, .cache_dirty_o
  );

endmodule

/* tb_cache_ref.svh */
// model of tags, valid, dirty and lines per way and set; tags and lines count as known only after a fill
`ifndef TB_CACHE_REF_SVH
`define TB_CACHE_REF_SVH

// one expected lookup result
typedef struct packed {
  logic                 vld;
  logic                 hit;
  logic [WAYS-1:0]      ways;
  cache_mem_pkg::line_t line;     // or of hit lines, zero on miss
  cache_mem_pkg::idx_t  idx;
  cache_mem_pkg::tag_t  etag;
  cache_mem_pkg::line_t eline;
  logic                 known;    // victim entry was filled at least once
  logic                 wdirty;
  logic                 cdirty;
} result_t;

cache_mem_pkg::tag_t  m_tag   [WAYS][cache_mem_pkg::SETS];
cache_mem_pkg::line_t m_line  [WAYS][cache_mem_pkg::SETS];
logic                 m_valid [WAYS][cache_mem_pkg::SETS];
logic                 m_dirty [WAYS][cache_mem_pkg::SETS];  // kept across flush
logic                 m_known [WAYS][cache_mem_pkg::SETS];

task automatic clear_model();
  for (int w = 0; w < WAYS; w++)
  begin
    for (int s = 0; s < cache_mem_pkg::SETS; s++)
    begin
      m_valid[w][s] = 1'b0;
      m_dirty[w][s] = 1'b0;
      m_known[w][s] = 1'b0;
    end
  end
endtask

// result of a lookup against the state before this edge
function automatic result_t predict(cache_mem_pkg::idx_t idx, cache_mem_pkg::tag_t tag,
                                    logic [WAYS-1:0] victim);
  result_t r;
  r     = '0;
  r.vld = 1'b1;
  r.idx = idx;
  for (int w = 0; w < WAYS; w++)
  begin
    if (m_valid[w][idx] && m_tag[w][idx] == tag)
    begin
      r.ways[w] = 1'b1;
      r.line    = r.line | m_line[w][idx];
    end
    if (victim[w])
    begin
      r.etag   = m_tag[w][idx];
      r.eline  = m_line[w][idx];
      r.known  = m_known[w][idx];
      r.wdirty = m_valid[w][idx] && m_dirty[w][idx];
    end
    for (int s = 0; s < cache_mem_pkg::SETS; s++)
      r.cdirty = r.cdirty | (m_valid[w][s] & m_dirty[w][s]);  // any valid dirty line
  end
  r.hit = |r.ways;
  return r;
endfunction

// fill, store and flush of the cycle that ends at this edge
task automatic update_model(logic store_go);
  int base;
  for (int w = 0; w < WAYS; w++)
  begin
    if (fill_i && fill_way_i[w])
    begin
      m_tag[w][fill_idx_i]   = fill_tag_i;
      m_line[w][fill_idx_i]  = fill_line_i;
      m_valid[w][fill_idx_i] = 1'b1;
      m_dirty[w][fill_idx_i] = fill_dirty_i;
      m_known[w][fill_idx_i] = 1'b1;
    end
    if (store_go && wb_ways_hit_i[w])
    begin
      base = int'(wb_offs_i) * cache_mem_pkg::XLEN;  // first bit of addressed word
      for (int b = 0; b < cache_mem_pkg::XLEN / 8; b++)
      begin
        if (wb_be_i[b])
          m_line[w][wb_idx_i][base + b*8 +: 8] = wb_data_i[b*8 +: 8];
      end
      m_dirty[w][wb_idx_i] = 1'b1;
    end
    if (flush_i)
    begin
      for (int s = 0; s < cache_mem_pkg::SETS; s++)
        m_valid[w][s] = 1'b0;  // also beats a fill in the same cycle
    end
  end
endtask

`endif

/* tb_cache_memory.sv */
// WAYS at its default; a store is held until wb_ack_o, results are checked from the first edge out of reset
`timescale 1ns/100ps

module tb_cache_memory;

  localparam int WAYS       = cache_mem_pkg::DEF_WAYS;
  localparam int CLK_PERIOD = 4;
  localparam int N_RANDOM   = 400;   // random traffic cycles
  localparam int N_DIRECTED = 100;   // upper bound for the directed phases
  localparam int ACK_LIMIT  = 32;
  localparam int TIMEOUT_NS = (N_DIRECTED + N_RANDOM) * CLK_PERIOD + 400;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic rreq_i, fill_i, fill_dirty_i, wb_req_i, flush_i;
  cache_mem_pkg::idx_t     rd_idx_i, fill_idx_i, wb_idx_i;
  cache_mem_pkg::tag_t     rd_tag_i, fill_tag_i;
  logic [WAYS-1:0]         victim_way_i, fill_way_i, wb_ways_hit_i;
  cache_mem_pkg::line_t    fill_line_i;
  cache_mem_pkg::offs_t    wb_offs_i;
  cache_mem_pkg::word_be_t wb_be_i;
  cache_mem_pkg::word_t    wb_data_i;
  logic                    result_valid_o, hit_o, way_dirty_o, cache_dirty_o, wb_ack_o;
  logic [WAYS-1:0]         ways_hit_o;
  cache_mem_pkg::line_t    cache_line_o, evict_line_o;
  cache_mem_pkg::idx_t     evict_idx_o;
  cache_mem_pkg::tag_t     evict_tag_o;

  int     errors = 0;
  int     checks = 0;
  integer seed   = 32'h5cd0;
  logic   store_busy = 1'b0;   // store waiting for its ack

  `include "tb_cache_ref.svh"

  result_t pipe [2];   // expected results, 2 edges deep

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  cache_memory_top #(.WAYS(WAYS)) cache_memory_top_i (.*);

  ////////////////////////////////////////
  // checking
  ////////////////////////////////////////

  task automatic count_error(string msg);
    errors++;
    $display("MISMATCH %0t: %s", $time, msg);
  endtask

  task automatic compare_field(string name, logic [127:0] got, logic [127:0] exp);
    checks++;
    assert (got === exp)
    else
      count_error($sformatf("%s got %0h expected %0h", name, got, exp));
  endtask

  task automatic check_result(result_t e);
    checks++;
    assert (result_valid_o === e.vld)  // exactly 2 edges after a performed lookup
    else
      count_error($sformatf("result_valid_o got %0b expected %0b", result_valid_o, e.vld));
    if (e.vld)
    begin
      compare_field("hit_o", 128'(hit_o), 128'(e.hit));
      compare_field("ways_hit_o", 128'(ways_hit_o), 128'(e.ways));
      compare_field("cache_line_o", cache_line_o, e.line);
      compare_field("evict_idx_o", 128'(evict_idx_o), 128'(e.idx));
      compare_field("way_dirty_o", 128'(way_dirty_o), 128'(e.wdirty));
      compare_field("cache_dirty_o", 128'(cache_dirty_o), 128'(e.cdirty));
      if (e.known)   // never filled entries hold no defined tag or line
      begin
        compare_field("evict_tag_o", 128'(evict_tag_o), 128'(e.etag));
        compare_field("evict_line_o", evict_line_o, e.eline);
      end
    end
  endtask

  // samples pre-edge values, stimulus lands after the edge
  always @(posedge clk_i)
  begin : model_check
    logic ack_exp;
    if (!rst_ni)
    begin
      clear_model();
      pipe[0] = '0;
      pipe[1] = '0;
    end
    else
    begin
      check_result(pipe[1]);
      ack_exp = wb_req_i && !flush_i && !fill_i && !rreq_i;   // free cycle only
      compare_field("wb_ack_o", 128'(wb_ack_o), 128'(ack_exp));
      pipe[1] = pipe[0];
      pipe[0] = '0;
      if (rreq_i && !fill_i && !flush_i)
        pipe[0] = predict(rd_idx_i, rd_tag_i, victim_way_i);
      update_model(ack_exp);
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  function automatic cache_mem_pkg::tag_t pick_tag(logic [1:0] sel);
    return {22'h2b4c1d, sel};   // small pool for hits
  endfunction

  function automatic logic [WAYS-1:0] one_hot(int k);
    logic [WAYS-1:0] m;
    m = '0;
    m[k % WAYS] = 1'b1;
    return m;
  endfunction

  // strobes drop each cycle, a store holds until acked
  task automatic next_cycle();
    @(posedge clk_i);
    if (store_busy && wb_ack_o)
    begin
      store_busy = 1'b0;
      wb_req_i <= 1'b0;
    end
    rreq_i  <= 1'b0;
    fill_i  <= 1'b0;
    flush_i <= 1'b0;
  endtask

  task automatic look_up(cache_mem_pkg::idx_t idx, cache_mem_pkg::tag_t tag,
                         logic [WAYS-1:0] victim);
    rreq_i       <= 1'b1;
    rd_idx_i     <= idx;
    rd_tag_i     <= tag;
    victim_way_i <= victim;
  endtask

  task automatic fill_line(cache_mem_pkg::idx_t idx, cache_mem_pkg::tag_t tag,
                           logic [WAYS-1:0] way, cache_mem_pkg::line_t line, logic dirty);
    fill_i       <= 1'b1;
    fill_idx_i   <= idx;
    fill_tag_i   <= tag;
    fill_way_i   <= way;
    fill_line_i  <= line;
    fill_dirty_i <= dirty;
  endtask

  task automatic flush_all();
    flush_i <= 1'b1;
  endtask

  task automatic post_store(cache_mem_pkg::idx_t idx, cache_mem_pkg::offs_t offs,
                            cache_mem_pkg::word_be_t be, cache_mem_pkg::word_t data,
                            logic [WAYS-1:0] ways);
    store_busy = 1'b1;
    wb_req_i      <= 1'b1;
    wb_idx_i      <= idx;
    wb_offs_i     <= offs;
    wb_be_i       <= be;
    wb_data_i     <= data;
    wb_ways_hit_i <= ways;
  endtask

  task automatic await_ack();
    int n;
    n = 0;
    while (store_busy && n < ACK_LIMIT)
    begin
      next_cycle();
      n++;
    end
    if (store_busy)
    begin
      errors++;
      $display("store request was not acknowledged within %0d cycles", ACK_LIMIT);
    end
  endtask

  initial
  begin
    logic [31:0] rnd;
    logic [31:0] rnd2;
    rst_ni <= 1'b0;
    rreq_i <= 1'b0;
    rd_idx_i <= '0;
    rd_tag_i <= '0;
    victim_way_i <= '0;
    fill_i <= 1'b0;
    fill_idx_i <= '0;
    fill_tag_i <= '0;
    fill_way_i <= '0;
    fill_line_i <= '0;
    fill_dirty_i <= 1'b0;
    wb_req_i <= 1'b0;
    wb_idx_i <= '0;
    wb_offs_i <= '0;
    wb_be_i <= '0;
    wb_data_i <= '0;
    wb_ways_hit_i <= '0;
    flush_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    // every set misses out of reset
    for (int s = 0; s < cache_mem_pkg::SETS; s++)
    begin
      next_cycle();
      look_up(cache_mem_pkg::idx_t'(s), pick_tag(2'd0), one_hot(s));
    end

    // fill two ways of set 3, then hit each and miss on a third tag
    next_cycle();
    fill_line(4'd3, pick_tag(2'd1), one_hot(0), 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210, 1'b0);
    next_cycle();
    fill_line(4'd3, pick_tag(2'd2), one_hot(1), 128'h1111_2222_3333_4444_5555_6666_7777_8888, 1'b0);
    next_cycle();
    look_up(4'd3, pick_tag(2'd1), one_hot(0));
    next_cycle();
    look_up(4'd3, pick_tag(2'd2), one_hot(1));
    next_cycle();
    look_up(4'd3, pick_tag(2'd3), one_hot(0));

    // store behind two lookups, acked in the first free cycle
    next_cycle();
    look_up(4'd3, pick_tag(2'd2), one_hot(1));
    post_store(4'd3, 2'd2, 4'b0101, 32'hdead_beef, one_hot(0));
    next_cycle();
    look_up(4'd3, pick_tag(2'd1), one_hot(0));
    await_ack();
    look_up(4'd3, pick_tag(2'd1), one_hot(0));   // stored way as victim, dirty
    next_cycle();
    look_up(4'd3, pick_tag(2'd1), one_hot(1));

    // flush beats a fill and a lookup in the same cycle
    // the fill still writes tag, line and dirty
    next_cycle();
    flush_all();
    fill_line(4'd5, pick_tag(2'd1), one_hot(1), 128'h5a5a_0f0f_c3c3_9696_a5a5_f0f0_3c3c_6969, 1'b1);
    look_up(4'd3, pick_tag(2'd1), one_hot(0));   // dropped, no result

    // flush, then every set misses again
    for (int s = 0; s < cache_mem_pkg::SETS; s++)
    begin
      next_cycle();
      look_up(cache_mem_pkg::idx_t'(s), pick_tag(2'd1), one_hot(s));
    end

    ////////////////////////////////////////
    // random traffic
    ////////////////////////////////////////

    for (int n = 0; n < N_RANDOM; n++)
    begin
      next_cycle();
      rnd  = $random(seed);
      rnd2 = $random(seed);
      if (rnd[6:0] == 7'd0)
        flush_all();   // rare
      else if (rnd[1:0] == 2'd0)
        fill_line(rnd[11:8], pick_tag(rnd[13:12]), one_hot(int'(rnd[15:14])),
                  {$random(seed), $random(seed), $random(seed), $random(seed)}, rnd[16]);
      if (rnd[17])
        look_up(rnd[22:19], pick_tag(rnd[24:23]), one_hot(int'(rnd[26:25])));
      if (!store_busy && rnd[28:27] == 2'd0)
        post_store(rnd2[3:0], rnd2[5:4], rnd2[9:6], $random(seed), rnd2[10 +: WAYS]);
    end
    await_ack();
    repeat (3) next_cycle();   // drain results in flight

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  // watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

endmodule

/* build.f */
+incdir+.
cache_mem_pkg.sv
cache_req_decode.sv
cache_tag_store.sv
cache_data_store.sv
cache_lookup_result.sv
cache_memory_top.sv
tb_cache_memory.sv

/* Makefile */
# Verilator build and run of the cache memory testbench

VERILATOR ?= verilator
TOP       ?= tb_cache_memory
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
FLAGS     ?= --timescale 1ns/100ps

PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJDIR FLAGS"

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+') tb_cache_ref.svh
	$(VERILATOR) --binary --timing --assert $(FLAGS) \
		--top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

test: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
